// File: ros2_app_pkg.sv
/* ROS2 application shared definitions */

package ros2_app_pkg;

    // Fixed text ahead of the message digit
    localparam logic [8*20-1:0] pub_text = "Message From FPGA - ";
    localparam logic [7:0] pub_text_len = 8'd20;

    // CDR string length counts the digit and the terminating zero
    localparam logic [31:0] pub_strlen = 32'(pub_text_len) + 32'd2;

    // Length word plus string bytes
    localparam logic [7:0] pub_msg_len = 8'd4 + pub_strlen[7:0];

    localparam logic [7:0] digit_first = "0";
    localparam logic [7:0] digit_last = "9";

    // Register map
    localparam logic [1:0] cfg_period_addr = 2'd0;
    localparam logic [1:0] cfg_enable_addr = 2'd1;
    localparam logic [1:0] cfg_rx_count_addr = 2'd2;
    localparam logic [1:0] cfg_tx_count_addr = 2'd3;

    localparam int period_w = 32;

endpackage

// File: app_if.sv
/* Publisher and subscriber buffer interfaces */

interface pub_req_if;
    logic req;
    logic rel;
    logic grant;
    logic [7:0] digit;

    modport requester (output req, output rel, output digit, input grant);
    modport grantor (input req, input rel, input digit, output grant);
endinterface

interface app_data_if #(
    parameter int depth = 32
);
    logic [$clog2(depth)-1:0] addr;
    logic ce;
    logic we;
    logic [7:0] wdata;

    modport writer (output addr, output ce, output we, output wdata);
    modport store (input addr, input ce, input we, input wdata);
endinterface

// File: node_cfg.sv
/* Node configuration registers */

module node_cfg #(
    parameter logic [ros2_app_pkg::period_w-1:0] default_period = 32'd1000
) (
    input  logic                              clk_int,
    input  logic                              rst_n,
    input  logic                              cfg_we,
    input  logic [1:0]                        cfg_addr,
    input  logic [31:0]                       cfg_wdata,
    output logic [31:0]                       cfg_rdata,
    input  logic                              tx_done,
    input  logic                              rx_done,
    output logic [ros2_app_pkg::period_w-1:0] period,
    output logic                              pub_en,
    output logic                              sub_en
);

    logic [31:0] tx_count;
    logic [31:0] rx_count;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            period <= default_period;
            pub_en <= 1'b0;
            sub_en <= 1'b0;
            tx_count <= '0;
            rx_count <= '0;
        end else begin
            if (cfg_we && cfg_addr == ros2_app_pkg::cfg_period_addr) begin
                period <= cfg_wdata[ros2_app_pkg::period_w-1:0];
            end
            if (cfg_we && cfg_addr == ros2_app_pkg::cfg_enable_addr) begin
                pub_en <= cfg_wdata[0];
                sub_en <= cfg_wdata[1];
            end
            // Counters hold at full scale
            if (tx_done && tx_count != '1) begin
                tx_count <= tx_count + 32'd1;
            end
            if (rx_done && rx_count != '1) begin
                rx_count <= rx_count + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            ros2_app_pkg::cfg_period_addr:   cfg_rdata = 32'(period);
            ros2_app_pkg::cfg_enable_addr:   cfg_rdata = {30'd0, sub_en, pub_en};
            ros2_app_pkg::cfg_rx_count_addr: cfg_rdata = rx_count;
            default:                         cfg_rdata = tx_count;
        endcase
    end

endmodule

// File: pub_msg_gen.sv
/* Publish interval and buffer request */

module pub_msg_gen (
    input  logic                              clk_int,
    input  logic                              rst_n,
    input  logic [ros2_app_pkg::period_w-1:0] period,
    input  logic                              pub_en,
    pub_req_if.requester                      req_if
);

    logic [ros2_app_pkg::period_w-1:0] timer;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            timer <= '0;
            req_if.req <= 1'b0;
            req_if.rel <= 1'b0;
            req_if.digit <= ros2_app_pkg::digit_first;
        end else begin
            req_if.rel <= 1'b0;

            // Buffer handed over, release it at once
            if (req_if.req && req_if.grant) begin
                req_if.req <= 1'b0;
                req_if.rel <= 1'b1;
            end else if (pub_en && !req_if.req && !req_if.rel && timer >= period) begin
                req_if.req <= 1'b1;
            end

            if (req_if.rel) begin
                timer <= '0;
                if (req_if.digit == ros2_app_pkg::digit_last) begin
                    req_if.digit <= ros2_app_pkg::digit_first;
                end else begin
                    req_if.digit <= req_if.digit + 8'd1;
                end
            end else if (pub_en && timer < period) begin
                // Stops at the period until the next release
                timer <= timer + 1'b1;
            end
        end
    end

endmodule

// File: pub_serializer.sv
/* CDR string message serializer */

module pub_serializer (
    input  logic        clk_int,
    input  logic        rst_n,
    pub_req_if.grantor  req_if,
    output logic        tx_valid,
    output logic [7:0]  tx_data,
    output logic        tx_last
);

    logic [7:0] byte_cnt;
    logic [7:0] txt_idx;
    logic [7:0] digit_q;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            req_if.grant <= 1'b0;
            tx_valid <= 1'b0;
            byte_cnt <= '0;
        end else begin
            if (!tx_valid && req_if.rel) begin
                req_if.grant <= 1'b0;
                tx_valid <= 1'b1;
                byte_cnt <= '0;
            end else if (!tx_valid && req_if.req && !req_if.grant) begin
                req_if.grant <= 1'b1;
            end else if (tx_valid) begin
                if (tx_last) begin
                    tx_valid <= 1'b0;
                end
                byte_cnt <= byte_cnt + 8'd1;
            end
        end
    end

    // Digit is held for the whole message
    always_ff @(posedge clk_int) begin
        if (!tx_valid && req_if.rel) begin
            digit_q <= req_if.digit;
        end
    end

    assign tx_last = tx_valid && (byte_cnt == ros2_app_pkg::pub_msg_len - 8'd1);

    always_comb begin
        txt_idx = byte_cnt - 8'd4;
        if (byte_cnt < 8'd4) begin
            // Length word goes out LSB first
            tx_data = ros2_app_pkg::pub_strlen[8*byte_cnt[1:0] +: 8];
        end else if (txt_idx < ros2_app_pkg::pub_text_len) begin
            tx_data = ros2_app_pkg::pub_text[
                8*(ros2_app_pkg::pub_text_len - 8'd1 - txt_idx) +: 8];
        end else if (txt_idx == ros2_app_pkg::pub_text_len) begin
            tx_data = digit_q;
        end else begin
            tx_data = 8'h00;
        end
    end

endmodule

// File: sub_deframer.sv
/* Received message deframer */

module sub_deframer #(
    parameter int rx_depth = 32,
    localparam int aw = $clog2(rx_depth)
) (
    input  logic        clk_int,
    input  logic        rst_n,
    input  logic        sub_en,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    input  logic        rx_last,
    app_data_if.writer  wr,
    output logic        sub_recv,
    output logic [15:0] sub_len,
    output logic        sub_err
);

    logic [15:0] byte_cnt;
    logic [15:0] byte_cnt_next;
    logic [15:0] str_idx;
    logic [15:0] str_cnt;
    logic [31:0] len_word;
    logic [31:0] len_next;

    always_comb begin
        byte_cnt_next = byte_cnt + 16'd1;
        str_idx = byte_cnt - 16'd4;
        str_cnt = byte_cnt_next - 16'd4;
        len_next = len_word;
        // First four bytes form the little-endian length word
        if (byte_cnt < 16'd4) begin
            len_next[8*byte_cnt[1:0] +: 8] = rx_data;
        end
    end

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            sub_recv <= 1'b0;
            sub_len <= '0;
            sub_err <= 1'b0;
            wr.ce <= 1'b0;
            wr.we <= 1'b0;
        end else begin
            sub_recv <= 1'b0;
            wr.ce <= 1'b0;
            wr.we <= 1'b0;
            if (!sub_en) begin
                byte_cnt <= '0;
            end else if (rx_valid) begin
                // Bytes past the store are counted only
                if (byte_cnt >= 16'd4 && str_idx < rx_depth) begin
                    wr.ce <= 1'b1;
                    wr.we <= 1'b1;
                end
                if (rx_last) begin
                    byte_cnt <= '0;
                    sub_recv <= 1'b1;
                    sub_len <= (byte_cnt_next < 16'd4) ? 16'd0 : str_cnt;
                    sub_err <= (byte_cnt_next < 16'd4) || (32'(str_cnt) != len_next);
                end else begin
                    byte_cnt <= byte_cnt_next;
                end
            end
        end
    end

    always_ff @(posedge clk_int) begin
        if (sub_en && rx_valid) begin
            len_word <= len_next;
            wr.addr <= str_idx[aw-1:0];
            wr.wdata <= rx_data;
        end
    end

endmodule

// File: sub_msg_store.sv
/* Received message store */

module sub_msg_store #(
    parameter int rx_depth = 32,
    localparam int aw = $clog2(rx_depth)
) (
    input  logic          clk_int,
    input  logic          rst_n,
    app_data_if.store     st,
    input  logic [aw-1:0] rd_addr,
    output logic [7:0]    rd_data,
    output logic [3:0]    led
);

    logic [7:0] mem [0:rx_depth-1];

    always_ff @(posedge clk_int) begin
        if (st.ce && st.we) begin
            mem[st.addr] <= st.wdata;
        end
        rd_data <= mem[rd_addr];
    end

    // LEDs follow the first string byte
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            led <= 4'h0;
        end else if (st.ce && st.we && st.addr == '0) begin
            led <= st.wdata[3:0];
        end
    end

endmodule

// File: ros2_app_top.sv
/* ROS2 node application top */

module ros2_app_top #(
    parameter logic [ros2_app_pkg::period_w-1:0] default_period = 32'd125000,
    parameter int rx_depth = 32,
    localparam int aw = $clog2(rx_depth)
) (
    input  logic          clk_int,
    input  logic          rst_n,
    input  logic          cfg_we,
    input  logic [1:0]    cfg_addr,
    input  logic [31:0]   cfg_wdata,
    output logic [31:0]   cfg_rdata,
    output logic          tx_valid,
    output logic [7:0]    tx_data,
    output logic          tx_last,
    input  logic          rx_valid,
    input  logic [7:0]    rx_data,
    input  logic          rx_last,
    output logic          sub_recv,
    output logic [15:0]   sub_len,
    output logic          sub_err,
    input  logic [aw-1:0] rd_addr,
    output logic [7:0]    rd_data,
    output logic [3:0]    led
);

    logic [ros2_app_pkg::period_w-1:0] period;
    logic pub_en;
    logic sub_en;

    pub_req_if u_pub_req ();
    app_data_if #(.depth(rx_depth)) u_app_data ();

    node_cfg #(
        .default_period(default_period)
    ) u_node_cfg (
        .clk_int   (clk_int),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .tx_done   (tx_last),
        .rx_done   (sub_recv),
        .period    (period),
        .pub_en    (pub_en),
        .sub_en    (sub_en)
    );

    // Publisher path
    pub_msg_gen u_pub_msg_gen (
        .clk_int (clk_int),
        .rst_n   (rst_n),
        .period  (period),
        .pub_en  (pub_en),
        .req_if  (u_pub_req.requester)
    );

    pub_serializer u_pub_serializer (
        .clk_int  (clk_int),
        .rst_n    (rst_n),
        .req_if   (u_pub_req.grantor),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_last  (tx_last)
    );

    // Subscriber path
    sub_deframer #(
        .rx_depth(rx_depth)
    ) u_sub_deframer (
        .clk_int  (clk_int),
        .rst_n    (rst_n),
        .sub_en   (sub_en),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_last  (rx_last),
        .wr       (u_app_data.writer),
        .sub_recv (sub_recv),
        .sub_len  (sub_len),
        .sub_err  (sub_err)
    );

    sub_msg_store #(
        .rx_depth(rx_depth)
    ) u_sub_msg_store (
        .clk_int (clk_int),
        .rst_n   (rst_n),
        .st      (u_app_data.store),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .led     (led)
    );

endmodule

// File: tb_ros2_app.sv
/* ROS2 application testbench */

module tb_ros2_app;

    localparam logic [31:0] tb_period = 32'd40;
    localparam int depth = 32;
    localparam int aw = $clog2(depth);

    logic clk_int;
    logic rst_n;
    logic cfg_we;
    logic [1:0] cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic tx_valid;
    logic [7:0] tx_data;
    logic tx_last;
    logic rx_valid;
    logic [7:0] rx_data;
    logic rx_last;
    logic sub_recv;
    logic [15:0] sub_len;
    logic sub_err;
    logic [aw-1:0] rd_addr;
    logic [7:0] rd_data;
    logic [3:0] led;

    string msg_text = "Message From FPGA - ";
    logic [31:0] rng;
    logic sub_on;
    logic [7:0] store_model [0:depth-1];
    logic [depth-1:0] store_valid;
    int unsigned cycle_cnt;
    int unsigned cycle_limit;

    ros2_app_top #(
        .default_period(tb_period),
        .rx_depth(depth)
    ) u_dut (
        .clk_int   (clk_int),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_last   (tx_last),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_last   (rx_last),
        .sub_recv  (sub_recv),
        .sub_len   (sub_len),
        .sub_err   (sub_err),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .led       (led)
    );

    initial begin
        clk_int = 1'b0;
        forever #20 clk_int = ~clk_int;
    end

    always @(posedge clk_int) begin
        cycle_cnt <= cycle_cnt + 32'd1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles waiting for the DUT", cycle_cnt);
            $display("TB FAILED");
            $fatal(1, "run timed out");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Length word LSB first, text, digit, zero byte
    function automatic logic [7:0] expected_tx_byte(input int idx, input logic [7:0] digit);
        logic [31:0] len_word;
        len_word = 32'(msg_text.len() + 2);
        if (idx < 4) begin
            return len_word[8*idx +: 8];
        end else if (idx - 4 < msg_text.len()) begin
            return msg_text[idx-4];
        end else if (idx - 4 == msg_text.len()) begin
            return digit;
        end
        return 8'h00;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopping on error");
    endtask

    task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("mismatch in %0s: expected %h, actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_int);
        #5;
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_we = 1'b0;
    endtask

    task automatic check_reg(input logic [8*24-1:0] name, input logic [1:0] addr,
                             input logic [31:0] expected);
        cfg_addr = addr;
        next_cycle();
        check_value(name, expected, cfg_rdata);
    endtask

    task automatic check_publish(input logic [8*24-1:0] name, input logic [7:0] digit);
        int idx;
        int msg_len;
        msg_len = msg_text.len() + 6;
        idx = 0;
        while (!tx_valid) begin
            next_cycle();
        end
        while (idx < msg_len) begin
            check_value(name, 32'd1, 32'(tx_valid));
            check_value(name, 32'(expected_tx_byte(idx, digit)), 32'(tx_data));
            check_value(name, 32'(idx == msg_len - 1), 32'(tx_last));
            idx++;
            next_cycle();
        end
        check_value(name, 32'd0, 32'(tx_valid));
    endtask

    task automatic check_store(input logic [8*24-1:0] name);
        int a;
        for (a = 0; a < depth; a++) begin
            rd_addr = aw'(a);
            next_cycle();
            if (store_valid[a]) begin
                check_value(name, 32'(store_model[a]), 32'(rd_data));
            end
        end
        if (store_valid[0]) begin
            check_value(name, 32'(store_model[0][3:0]), 32'(led));
        end
    endtask

    task automatic run_receive(input logic [8*24-1:0] name, input logic [31:0] len_word,
                               input int count, input logic err);
        int total;
        int i;
        logic [7:0] b;
        total = count + 4;
        for (i = 0; i < total; i++) begin
            if (i < 4) begin
                b = len_word[8*i +: 8];
            end else begin
                rng = xorshift32(rng);
                b = rng[7:0];
            end
            rx_valid = 1'b1;
            rx_data = b;
            rx_last = (i == total - 1);
            // Only the first depth string bytes land in the store
            if (sub_on && i >= 4 && i - 4 < depth) begin
                store_model[i-4] = b;
                store_valid[i-4] = 1'b1;
            end
            next_cycle();
            if (!sub_on) begin
                check_value(name, 32'd0, 32'(sub_recv));
            end
        end
        rx_valid = 1'b0;
        rx_last = 1'b0;
        rx_data = 8'h00;
        if (sub_on) begin
            while (!sub_recv) begin
                next_cycle();
            end
            check_value(name, 32'(count), 32'(sub_len));
            check_value(name, 32'(err), 32'(sub_err));
        end else begin
            repeat (4) begin
                check_value(name, 32'd0, 32'(sub_recv));
                next_cycle();
            end
        end
        check_store(name);
    endtask

    task automatic run_case(input logic [7:0] cmd, input logic [8*24-1:0] name,
                            input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
        case (cmd)
            "w": begin
                write_reg(a[1:0], b);
                if (a[1:0] == 2'd1) begin
                    sub_on = b[1];
                end
            end
            "r": check_reg(name, a[1:0], b);
            "p": check_publish(name, a[7:0]);
            "x": run_receive(name, a, int'(b), c[0]);
            default: report_failure("unknown command in the cases file");
        endcase
    endtask

    initial begin
        int fd;
        int n;
        int n_cases;
        logic [31:0] max_period;
        logic [8*96-1:0] line;
        logic [7:0] cmd;
        logic [8*24-1:0] name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;

        cfg_we = 1'b0;
        cfg_addr = 2'd0;
        cfg_wdata = 32'd0;
        rx_valid = 1'b0;
        rx_data = 8'h00;
        rx_last = 1'b0;
        rd_addr = '0;
        rng = 32'hc1bf;
        sub_on = 1'b0;
        store_valid = '0;
        cycle_limit = 0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk_int);
        #5;
        rst_n = 1'b1;

        // Count the cases and find the longest period for the run limit
        fd = $fopen("ros2_app_cases.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open ros2_app_cases.txt");
        end
        n_cases = 0;
        max_period = tb_period;
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h", cmd, name, a, b, c);
                if (n == 5 && cmd != "#") begin
                    n_cases++;
                    if (cmd == "w" && a == 32'd0 && b > max_period) begin
                        max_period = b;
                    end
                end
            end
        end
        $fclose(fd);
        cycle_limit = cycle_cnt + 32'(n_cases) * 32'd4 *
                      (max_period + 32'(msg_text.len() + 6));

        repeat (4) begin
            check_value("reset_idle", 32'd0, 32'(tx_valid));
            check_value("reset_idle", 32'd0, 32'(sub_recv));
            next_cycle();
        end

        fd = $fopen("ros2_app_cases.txt", "r");
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h", cmd, name, a, b, c);
                if (n == 5 && cmd != "#") begin
                    run_case(cmd, name, a, b, c);
                end else if (n > 0 && cmd != "#") begin
                    report_failure("malformed line in the cases file");
                end
            end
        end
        $fclose(fd);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: ros2_app_cases.txt
# Columns: command name a b c, numbers in hex
# w writes register a with b, r reads register a and expects b
# p captures one published message and expects digit a
# x sends length word a with b string bytes and expects error flag c
r reset_period      0  28 0
r reset_enable      1  0  0
r reset_rx_count    2  0  0
r reset_tx_count    3  0  0
w set_period        0  30 0
r period_readback   0  30 0
w set_enables       1  3  0
r enable_readback   1  3  0
w pub_only          1  1  0
p digit_0           30 0  0
p digit_1           31 0  0
p digit_2           32 0  0
p digit_3           33 0  0
p digit_4           34 0  0
p digit_5           35 0  0
p digit_6           36 0  0
p digit_7           37 0  0
p digit_8           38 0  0
p digit_9           39 0  0
p digit_wrap_0      30 0  0
p digit_wrap_1      31 0  0
w pub_off           1  0  0
r tx_count          3  c  0
w sub_on            1  2  0
x rx_good           14 14 0
x rx_full           20 20 0
x rx_len_error      10 c  1
x rx_overflow       28 28 0
r rx_count          2  4  0
w sub_off           1  0  0
x rx_disabled       8  8  0
r rx_count_hold     2  4  0

// File: tb.f
ros2_app_pkg.sv
app_if.sv
node_cfg.sv
pub_msg_gen.sv
pub_serializer.sv
sub_deframer.sv
sub_msg_store.sv
ros2_app_top.sv
tb_ros2_app.sv

// File: Makefile
# Verilator build and run of the ROS2 application testbench

obj_dir/Vtb_ros2_app: tb.f $(wildcard *.sv)
	verilator --binary --timing -f tb.f --top-module tb_ros2_app -o Vtb_ros2_app

run: obj_dir/Vtb_ros2_app
	./obj_dir/Vtb_ros2_app

clean:
	rm -rf obj_dir

.PHONY: run clean
